// ==== data_mem.f ====
verilog/data_mem_pkg.sv
verilog/mem_req_if.sv
verilog/mem_access_decode.sv
verilog/word_store.sv
verilog/load_align.sv
verilog/data_mem_top.sv
sim/data_mem_properties.sv
sim/tb_data_mem.sv

// ==== Makefile ====
SIM     = verilator
VFLAGS  = --binary --timing --assert
TOP     = tb_data_mem
FLIST   = data_mem.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Errors found" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_data_mem.sv ====
`timescale 1ns/1ps

module tb_data_mem;

    localparam int DEPTH_WORDS = 256;
    localparam int MEM_BYTES   = DEPTH_WORDS * 4;
    localparam int ADDR_W      = $clog2(MEM_BYTES);
    localparam int CLK_PERIOD  = 8;
    localparam int NUM_RANDOM  = 1200;
    // Reset, fill pass, random pass and the closing idle cycle, plus some slack
    localparam int WATCHDOG_NS = (3 + DEPTH_WORDS + NUM_RANDOM + 1) * CLK_PERIOD + 200;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        ce_i;
    logic        req_i;
    logic        we_i;
    logic [1:0]  hb_i;
    logic [31:0] addr_i;
    logic [31:0] wdata_i;
    logic        gnt_o;
    logic        misalign_o;
    logic [31:0] rdata_o;

    // Byte-wide copy of the memory, lane 0 at the lowest address
    logic [7:0]  shadow [MEM_BYTES];
    logic [31:0] exp_rdata;
    logic        exp_misalign;
    integer      seed;
    int          errors;
    int          checks;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    data_mem_top #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) data_mem_top_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ce_i       (ce_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .hb_i       (hb_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .gnt_o      (gnt_o),
        .misalign_o (misalign_o),
        .rdata_o    (rdata_o)
    );

    bind data_mem_top data_mem_properties data_mem_properties_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ce_i       (ce_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .hb_i       (hb_i),
        .addr_i     (addr_i),
        .gnt_o      (gnt_o),
        .misalign_o (misalign_o),
        .rdata_o    (rdata_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic misaligned_access(input logic [1:0] hb,
                                               input logic [ADDR_W-1:0] a);
        if (hb == data_mem_pkg::SIZE_BYTE) begin
            return 1'b0;
        end else if (hb == data_mem_pkg::SIZE_HALF) begin
            return a[0];
        end
        return (a[1:0] != 2'b00);
    endfunction

    function automatic logic [31:0] expected_load(input logic [1:0] hb,
                                                  input logic [ADDR_W-1:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[a];
        h = {shadow[{a[ADDR_W-1:1], 1'b1}], shadow[a]};
        if (hb == data_mem_pkg::SIZE_BYTE) begin
            return {{24{b[7]}}, b};
        end else if (hb == data_mem_pkg::SIZE_HALF) begin
            return {{16{h[15]}}, h};
        end
        return {shadow[{a[ADDR_W-1:2], 2'd3}], shadow[{a[ADDR_W-1:2], 2'd2}],
                shadow[{a[ADDR_W-1:2], 2'd1}], shadow[a]};
    endfunction

    // Predicts the outputs for the cycle after this access and applies stores
    task automatic model_access(input logic ce, input logic req, input logic we,
                                input logic [1:0] hb, input logic [31:0] addr,
                                input logic [31:0] data);
        logic [ADDR_W-1:0] a;
        logic              mis;
        a            = addr[ADDR_W-1:0];
        mis          = misaligned_access(hb, a);
        exp_misalign = ce && req && mis;
        exp_rdata    = '0;
        if (ce && req && !mis) begin
            if (!we) begin
                exp_rdata = expected_load(hb, a);
            end else if (hb == data_mem_pkg::SIZE_BYTE) begin
                shadow[a] = data[7:0];
            end else if (hb == data_mem_pkg::SIZE_HALF) begin
                shadow[a]                       = data[7:0];
                shadow[{a[ADDR_W-1:1], 1'b1}] = data[15:8];
            end else begin
                shadow[a]                       = data[7:0];
                shadow[{a[ADDR_W-1:2], 2'd1}] = data[15:8];
                shadow[{a[ADDR_W-1:2], 2'd2}] = data[23:16];
                shadow[{a[ADDR_W-1:2], 2'd3}] = data[31:24];
            end
        end
    endtask

    task automatic compare_outputs();
        checks += 2;
        assert (rdata_o === exp_rdata) else begin
            errors++;
            $display("error at %0t: rdata_o is %h, expected %h", $time, rdata_o, exp_rdata);
        end
        assert (misalign_o === exp_misalign) else begin
            errors++;
            $display("error at %0t: misalign_o is %b, expected %b",
                     $time, misalign_o, exp_misalign);
        end
    endtask

    // One access per cycle; outputs of the previous access are checked mid-cycle
    task automatic apply_access(input logic ce, input logic req, input logic we,
                                input logic [1:0] hb, input logic [31:0] addr,
                                input logic [31:0] data);
        @(posedge clk_i);
        ce_i    <= ce;
        req_i   <= req;
        we_i    <= we;
        hb_i    <= hb;
        addr_i  <= addr;
        wdata_i <= data;
        @(negedge clk_i);
        compare_outputs();
        model_access(ce, req, we, hb, addr, data);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        rst_n_i      = 1'b0;
        ce_i         = 1'b0;
        req_i        = 1'b0;
        we_i         = 1'b0;
        hb_i         = data_mem_pkg::SIZE_BYTE;
        addr_i       = '0;
        wdata_i      = '0;
        exp_rdata    = '0;
        exp_misalign = 1'b0;
        errors       = 0;
        checks       = 0;
        seed         = 75;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // The array has no reset, so every word gets a known value first
        for (int w = 0; w < DEPTH_WORDS; w++) begin
            apply_access(1'b1, 1'b1, 1'b1, data_mem_pkg::SIZE_WORD, w * 4, $random(seed));
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd              = $random(seed);
            addr             = '0;
            addr[ADDR_W-1:0] = rnd[ADDR_W+8:9];
            apply_access(rnd[2:0] != 3'd0, rnd[5:3] != 3'd0, rnd[6], rnd[8:7],
                         addr, $random(seed));
        end
        apply_access(1'b0, 1'b0, 1'b0, data_mem_pkg::SIZE_WORD, '0, '0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all accesses were issued");
        $display("Errors found");
        $finish;
    end

endmodule

// ==== sim/data_mem_properties.sv ====
`timescale 1ns/1ps

module data_mem_properties (
    input logic                            clk_i,
    input logic                            rst_n_i,
    input logic                            ce_i,
    input logic                            req_i,
    input logic                            we_i,
    input logic [1:0]                      hb_i,
    input logic [31:0]                     addr_i,
    input logic                            gnt_o,
    input logic                            misalign_o,
    input logic [data_mem_pkg::DATA_W-1:0] rdata_o
);

    logic accepted;
    logic misaligned;

    assign accepted   = req_i && ce_i;
    // Halfwords need an even address, and words and code 11 (bit 1 set) a multiple of four
    assign misaligned = ((hb_i == data_mem_pkg::SIZE_HALF) && addr_i[0]) ||
                        (hb_i[1] && (addr_i[1:0] != 2'b00));

    grant_follows_request: assert property (@(posedge clk_i) gnt_o == accepted)
        else $error("Grant is not the AND of req_i and ce_i");

    misaligned_raises_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accepted && misaligned |=> misalign_o)
        else $error("Misaligned access did not raise misalign_o");

    aligned_keeps_pulse_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(accepted && misaligned) |=> !misalign_o)
        else $error("misalign_o rose without a misaligned access");

    idle_read_is_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(accepted && !misaligned && !we_i) |=> rdata_o == '0)
        else $error("rdata_o is not zero after a cycle without an accepted load");

    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (rdata_o == '0) && !misalign_o)
        else $error("Outputs are not quiet right after reset");

endmodule

// ==== verilog/data_mem_top.sv ====
`timescale 1ns/1ps

module data_mem_top #(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            ce_i,
    input  logic                            req_i,
    input  logic                            we_i,
    input  logic [1:0]                      hb_i,
    input  logic [31:0]                     addr_i,
    input  logic [data_mem_pkg::DATA_W-1:0] wdata_i,
    output logic                            gnt_o,
    output logic                            misalign_o,
    output logic [data_mem_pkg::DATA_W-1:0] rdata_o
);

    // Raw word from the RAM, one cycle after the load request
    logic [data_mem_pkg::DATA_W-1:0] raw_word;

    mem_req_if #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) acc_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode, storage, alignment
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_access_decode #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) mem_access_decode_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ce_i       (ce_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .hb_i       (hb_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .gnt_o      (gnt_o),
        .misalign_o (misalign_o),
        .acc_o      (acc_if.decoder)
    );

    word_store #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) word_store_inst (
        .clk_i   (clk_i),
        .acc_i   (acc_if.store),
        .rdata_o (raw_word)
    );

    load_align load_align_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .raw_word_i (raw_word),
        .acc_i      (acc_if.align),
        .rdata_o    (rdata_o)
    );

endmodule

// ==== verilog/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [data_mem_pkg::DATA_W-1:0] raw_word_i,
    mem_req_if.align                        acc_i,
    output logic [data_mem_pkg::DATA_W-1:0] rdata_o
);

    logic                    rd_q;
    logic [1:0]              size_q;
    logic [1:0]              offset_q;
    data_mem_pkg::mem_word_u raw_u;
    logic [7:0]              sel_byte;
    logic [15:0]             sel_half;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request-cycle attributes, lined up with the RAM read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= acc_i.rd_en;
        end
    end

    // Only looked at while rd_q is high
    always_ff @(posedge clk_i) begin
        if (acc_i.rd_en) begin
            size_q   <= acc_i.size;
            offset_q <= acc_i.offset;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane select and sign extension
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign raw_u    = raw_word_i;
    assign sel_byte = raw_u.bytes[offset_q];
    assign sel_half = raw_u.halves[offset_q[1]];

    always_comb begin
        rdata_o = '0;
        if (rd_q) begin
            case (size_q)
                data_mem_pkg::SIZE_BYTE: begin
                    rdata_o = {{(data_mem_pkg::DATA_W-8){sel_byte[7]}}, sel_byte};
                end
                data_mem_pkg::SIZE_HALF: begin
                    rdata_o = {{(data_mem_pkg::DATA_W-16){sel_half[15]}}, sel_half};
                end
                default: begin
                    // Word access, size code 11 included
                    rdata_o = raw_u;
                end
            endcase
        end
    end

endmodule

// ==== verilog/word_store.sv ====
`timescale 1ns/1ps

module word_store #(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic                            clk_i,
    mem_req_if.store                        acc_i,
    output logic [data_mem_pkg::DATA_W-1:0] rdata_o
);

    localparam int LANES = data_mem_pkg::DATA_W / 8;

    logic [data_mem_pkg::DATA_W-1:0] mem_q [DEPTH_WORDS];
    logic [data_mem_pkg::DATA_W-1:0] rdata_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte-enabled write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Write data already sits in every lane, so only the enables matter
    always_ff @(posedge clk_i) begin
        if (acc_i.wr_en) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (acc_i.be[lane]) begin
                    mem_q[acc_i.word_idx][lane*8 +: 8] <= acc_i.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Holds its last value on idle cycles, load_align zeroes the output
    always_ff @(posedge clk_i) begin
        if (acc_i.rd_en) begin
            rdata_q <= mem_q[acc_i.word_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== verilog/mem_access_decode.sv ====
`timescale 1ns/1ps

module mem_access_decode #(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            ce_i,
    input  logic                            req_i,
    input  logic                            we_i,
    input  logic [1:0]                      hb_i,
    input  logic [31:0]                     addr_i,
    input  logic [data_mem_pkg::DATA_W-1:0] wdata_i,
    output logic                            gnt_o,
    output logic                            misalign_o,
    mem_req_if.decoder                      acc_o
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    logic                    is_byte;
    logic                    is_half;
    logic                    misaligned;
    logic                    accepted;
    logic                    misalign_q;
    logic [3:0]              be;
    data_mem_pkg::mem_word_u wdata_rep;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Size decode and alignment check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign is_byte = (hb_i == data_mem_pkg::SIZE_BYTE);
    assign is_half = (hb_i == data_mem_pkg::SIZE_HALF);

    // Anything that is not a byte or half is handled as a word
    assign misaligned = is_half ? addr_i[0] : (!is_byte && (addr_i[1:0] != 2'b00));

    assign accepted = req_i & ce_i;
    assign gnt_o    = accepted;

    // Lanes touched by the access, and store data copied into every lane
    always_comb begin
        if (is_byte) begin
            be              = 4'b0001 << addr_i[1:0];
            wdata_rep.bytes = {4{wdata_i[7:0]}};
        end else if (is_half) begin
            be               = addr_i[1] ? 4'b1100 : 4'b0011;
            wdata_rep.halves = {2{wdata_i[15:0]}};
        end else begin
            be              = 4'b1111;
            wdata_rep.bytes = wdata_i;
        end
    end

    assign acc_o.word_idx = addr_i[IDX_W+1:2];
    assign acc_o.be       = be;
    assign acc_o.wdata    = wdata_rep;
    assign acc_o.wr_en    = accepted & ~misaligned & we_i;
    assign acc_o.rd_en    = accepted & ~misaligned & ~we_i;
    assign acc_o.size     = hb_i;
    assign acc_o.offset   = addr_i[1:0];

    // One-cycle flag for a suppressed access
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            misalign_q <= 1'b0;
        end else begin
            misalign_q <= accepted & misaligned;
        end
    end

    assign misalign_o = misalign_q;

endmodule

// ==== verilog/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if #(
    parameter int DEPTH_WORDS = 1024
) ();

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    // Decoded access, valid only in the request cycle
    logic [IDX_W-1:0]                word_idx;
    logic [3:0]                      be;
    logic [data_mem_pkg::DATA_W-1:0] wdata;
    logic                            wr_en;
    logic                            rd_en;
    logic [1:0]                      size;
    logic [1:0]                      offset;

    modport decoder (
        output word_idx, be, wdata, wr_en, rd_en, size, offset
    );

    modport store (
        input word_idx, be, wdata, wr_en, rd_en
    );

    // The align side only needs what selects the lane a cycle later
    modport align (
        input rd_en, size, offset
    );

endinterface

// ==== verilog/data_mem_pkg.sv ====
package data_mem_pkg;

    // Width of one memory word and of the data buses
    localparam int DATA_W = 32;

    // Access size codes on hb_i, 2'b11 falls through to a word access
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One stored word seen as byte lanes or as halfword lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Lane 0 sits at the lowest byte address (little endian)
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage
